//--- Makefile
# Verilator build and run of the ALU testbench

LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sim.f --top-module tb_ula -o Vtb_ula

run: build
	./obj_dir/Vtb_ula | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "test passed" $(LOG) || { echo "No result in $(LOG)"; exit 1; }

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module ula

clean:
	rm -rf obj_dir $(LOG)

//--- sim.f
ula_pkg.sv
ula_arith.sv
ula_fsign.sv
ula_logic.sv
ula_cond.sv
ula_mux.sv
ula.sv
tb_ula.sv

//--- tb_ula.sv
// *************************************************************************
// Random testbench for the ALU with expected words from a model below
// Results are checked on the falling edge after they register
// *************************************************************************

`timescale 1ns/1ps
`default_nettype none

module tb_ula;

import ula_pkg::*;

logic                clk;
logic                reset;
logic [OP_W-1:0]     op;
ula_word_u           in1;
ula_word_u           in2;
ula_word_u           out;

logic [31:0]         lfsr = 32'd70;        // Random state
int                  cycle_n = 0;          // Falling edges so far
int                  checks = 0;
int                  errors = 0;
int                  tests = 0;
int                  failing = 0;

int                  due_q[$];             // Falling edge where a result is due
logic [NUBITS-1:0]   exp_q[$];
string               name_q[$];

// Op lists per group
logic [OP_W-1:0] arith_ops [11] = '{OP_NOP, OP_LOD, OP_ADD, OP_MLT, OP_SGN, OP_NEG,
	OP_NEG_M, OP_ABS, OP_ABS_M, OP_PST, OP_PST_M};
logic [OP_W-1:0] float_ops [7] = '{OP_F_SGN, OP_F_NEG, OP_F_NEG_M, OP_F_ABS, OP_F_ABS_M,
	OP_F_PST, OP_F_PST_M};
logic [OP_W-1:0] bit_ops [8] = '{OP_AND, OP_ORR, OP_XOR, OP_INV, OP_INV_M, OP_SHL,
	OP_SHR, OP_SRS};
logic [OP_W-1:0] cond_ops [7] = '{OP_LAN, OP_LOR, OP_LIN, OP_LIN_M, OP_LES, OP_GRE,
	OP_EQU};
logic [OP_W-1:0] spare_ops [13] = '{6'd3, 6'd5, 6'd6, 6'd7, 6'd8, 6'd23, 6'd24, 6'd25,
	6'd26, 6'd27, 6'd28, 6'd39, 6'd41};

ula ula_inst (
	.clk   (clk),
	.reset (reset),
	.op    (op),
	.in1   (in1),
	.in2   (in2),
	.out   (out)
);

initial begin
	clk = 1'b0;
	forever #5 clk = ~clk;                 // 10 ns period
end

// Random numbers **********************************************************

// Galois LFSR on x^32 + x^22 + x^2 + x + 1 stepped once per bit
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	logic        b;
	int          k;
	v = '0;
	for (k = 0; k < n; k++) begin
		b    = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'h8020_0003;
		v = {v[30:0], b};
	end
	return v;
endfunction

// Corner values mixed with plain random words
function automatic logic [31:0] rand_operand();
	case (rand_bits(3))
		32'd0:   return 32'd0;
		32'd1:   return 32'h8000_0000;     // Most negative
		32'd2:   return 32'hFFFF_FFFF;
		32'd3:   return rand_bits(4);
		32'd4:   return 32'h7FFF_FFFF;
		default: return rand_bits(32);
	endcase
endfunction

function automatic logic [31:0] rand_float();
	ula_word_u   w;
	logic [31:0] t;
	t = rand_bits(1);
	w.f.s = t[0];
	t = rand_bits(8);
	w.f.e = t[7:0];
	t = rand_bits(23);
	w.f.m = t[22:0];
	return w.i;
endfunction

// Shift amounts around the word edge
function automatic logic [31:0] pick_amount();
	case (rand_bits(3))
		32'd0:   return 32'd0;
		32'd1:   return 32'd31;
		32'd2:   return 32'd32;
		32'd3:   return 32'd33 + rand_bits(6);
		32'd4:   return rand_bits(32);
		default: return rand_bits(5);
	endcase
endfunction

function automatic logic [OP_W-1:0] pick_op(input int g);
	int idx;
	case (g)
		0: return arith_ops[int'(rand_bits(8) % 32'd11)];
		1: return float_ops[int'(rand_bits(8) % 32'd7)];
		2: return bit_ops[int'(rand_bits(3))];
		3: return cond_ops[int'(rand_bits(8) % 32'd7)];
		default: begin
			idx = int'(rand_bits(8) % 32'd31);
			if (idx < 13)
				return spare_ops[idx];
			return 6'(idx + 33);           // 46 to 63
		end
	endcase
endfunction

// Reference model *********************************************************

function automatic logic [31:0] model(input logic [OP_W-1:0] code,
		input logic [31:0] a, input logic [31:0] b);
	ula_word_u   fa;
	ula_word_u   fb;
	ula_word_u   r;
	logic [63:0] prod;
	logic [31:0] s;
	int          n;
	int          k;
	fa.i = a;
	fb.i = b;
	r.i  = '0;
	prod = {32'd0, a} * {32'd0, b};
	case (code)
		OP_NOP:     r.i = b;
		OP_LOD:     r.i = a;
		OP_ADD:     r.i = a + b;
		OP_MLT:     r.i = prod[31:0];
		OP_SGN:     r.i = (a[31] == b[31]) ? b : ~b + 32'd1;
		OP_NEG:     r.i = ~b + 32'd1;
		OP_NEG_M:   r.i = ~a + 32'd1;
		OP_ABS:     r.i = b[31] ? ~b + 32'd1 : b;
		OP_ABS_M:   r.i = a[31] ? ~a + 32'd1 : a;
		OP_PST:     r.i = b[31] ? 32'd0 : b;
		OP_PST_M:   r.i = a[31] ? 32'd0 : a;
		OP_F_SGN: begin
			r     = fb;
			r.f.s = fa.f.s;
		end
		OP_F_NEG: begin
			r     = fb;
			r.f.s = !fb.f.s;
		end
		OP_F_NEG_M: begin
			r     = fa;
			r.f.s = !fa.f.s;
		end
		OP_F_ABS: begin
			r     = fb;
			r.f.s = 1'b0;
		end
		OP_F_ABS_M: begin
			r     = fa;
			r.f.s = 1'b0;
		end
		OP_F_PST:   r = fb;
		OP_F_PST_M: r = fa;
		OP_AND:     r.i = a & b;
		OP_ORR:     r.i = a | b;
		OP_XOR:     r.i = a ^ b;
		OP_INV:     r.i = ~b;
		OP_INV_M:   r.i = ~a;
		OP_LAN:     r.i = (a != 0 && b != 0) ? 32'd1 : 32'd0;
		OP_LOR:     r.i = (a != 0 || b != 0) ? 32'd1 : 32'd0;
		OP_LIN:     r.i = (b == 0) ? 32'd1 : 32'd0;
		OP_LIN_M:   r.i = (a == 0) ? 32'd1 : 32'd0;
		OP_LES:     r.i = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
		OP_GRE:     r.i = ((b ^ 32'h8000_0000) < (a ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
		OP_EQU:     r.i = (a == b) ? 32'd1 : 32'd0;
		OP_SHL:     r.i = (b < 32) ? a << b : 32'd0;
		OP_SHR:     r.i = (b < 32) ? a >> b : 32'd0;
		OP_SRS: begin
			n = (b < 32) ? int'(b) : 32;
			s = a;
			for (k = 0; k < n; k++)
				s = {s[31], s[31:1]};      // One sign-filled step
			r.i = s;
		end
		default:    r.i = '0;
	endcase
	// Negative float becomes sign 0, exponent -128, mantissa 0
	if ((code == OP_F_PST && fb.f.s) || (code == OP_F_PST_M && fa.f.s)) begin
		r.f.s = 1'b0;
		r.f.e = 8'h80;
		r.f.m = '0;
	end
	return r.i;
endfunction

// Checking ****************************************************************

task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
	checks++;
	assert (act === exp) else begin
		$display("** Error [%s] expected %h, actual %h", name, exp, act);
		errors++;
	end
endtask

task automatic expect_word(input int due, input logic [31:0] exp, input string name);
	due_q.push_back(due);
	exp_q.push_back(exp);
	name_q.push_back(name);
endtask

always @(negedge clk) begin
	cycle_n++;
	if (due_q.size() > 0 && due_q[0] == cycle_n) begin
		check_word(name_q[0], exp_q[0], out.i);
		void'(due_q.pop_front());
		void'(exp_q.pop_front());
		void'(name_q.pop_front());
	end
end

// Drive on the rising edge with the result due two falling edges later
task automatic issue(input logic [OP_W-1:0] code, input logic [31:0] a,
		input logic [31:0] b, input string name);
	@(posedge clk);
	op  <= code;
	in1 <= a;
	in2 <= b;
	expect_word(cycle_n + 2, model(code, a, b), $sformatf("%s op %0d", name, code));
endtask

task automatic drain(input string name);
	int t;
	t = 0;
	while (due_q.size() > 0 && t < 20) begin
		@(posedge clk);
		t++;
	end
	if (due_q.size() > 0) begin
		$display("Timeout in %s, %0d results never came due", name, due_q.size());
		errors++;
		due_q.delete();
		exp_q.delete();
		name_q.delete();
	end
endtask

task automatic report_test(input string name, input int err0, input int chk0);
	tests++;
	if (errors == err0) begin
		$display("%-14s ok, %0d checks", name, checks - chk0);
	end else begin
		$display("%-14s FAILED, %0d errors", name, errors - err0);
		failing++;
	end
endtask

// Tests *******************************************************************

task automatic run_reset_idle();
	logic [31:0] v;
	int          k;
	v = rand_bits(32) | 32'd1;             // Never zero
	@(posedge clk);
	op  <= OP_LOD;                         // Ignored while reset is high
	in1 <= v;
	in2 <= ~v;
	expect_word(cycle_n + 1, 32'd0, "reset_idle");
	@(posedge clk);
	reset <= 1'b0;
	expect_word(cycle_n + 1, 32'd0, "reset_idle");
	for (k = 2; k < 6; k++)
		expect_word(cycle_n + k, v, "reset_idle hold");
	drain("reset_idle");
	report_test("reset_idle", 0, 0);
endtask

// Groups 0 arith, 1 float, 2 bitwise, 3 cond, 4 any kept, 5 spare codes
task automatic run_random(input string name, input int group, input int count);
	int              err0;
	int              chk0;
	int              g;
	int              n;
	logic [OP_W-1:0] code;
	logic [31:0]     a;
	logic [31:0]     b;
	logic [31:0]     t;
	err0 = errors;
	chk0 = checks;
	for (n = 0; n < count; n++) begin
		g = (group == 4) ? int'(rand_bits(2)) : group;
		code = pick_op(g);
		a = (g == 1) ? rand_float() : rand_operand();
		b = (g == 1) ? rand_float() : rand_operand();
		t = rand_bits(3);
		if (g == 2 && (code == OP_SHL || code == OP_SHR || code == OP_SRS))
			b = pick_amount();
		else if (t == 0)
			b = a;                         // Equal operands
		else if (t == 1 && g == 3)
			a = '0;
		issue(code, a, b, name);
	end
	drain(name);
	report_test(name, err0, chk0);
endtask

initial begin
	reset = 1'b1;
	op    = '0;
	in1   = '0;
	in2   = '0;
	run_reset_idle();
	run_random("integer_arith", 0, 150);
	run_random("float_sign", 1, 120);
	run_random("bitwise_shift", 2, 150);
	run_random("cond_compare", 3, 120);
	run_random("streaming", 4, 200);
	run_random("unknown_codes", 5, 60);
	$display("Summary %0d tests, %0d failing, %0d checks, %0d errors",
		tests, failing, checks, errors);
	if (errors == 0)
		$display("test passed");
	else
		$display("test failed");
	$finish;
end

endmodule

`default_nettype wire

//--- ula.sv
// *************************************************************************
// ALU top, every operation has exactly one cycle of latency
// A new op may issue every cycle, there is no handshake or back-pressure
// *************************************************************************

`timescale 1ns/1ps
`default_nettype none

module ula (
	input  logic                     clk,
	input  logic                     reset,
	input  logic [ula_pkg::OP_W-1:0] op,
	input  ula_pkg::ula_word_u       in1,      // Memory operand
	input  ula_pkg::ula_word_u       in2,      // Accumulator operand
	output ula_pkg::ula_word_u       out
);

import ula_pkg::*;

// Unit results ************************************************************

logic [NUBITS-1:0] add;
logic [NUBITS-1:0] mlt;
logic [NUBITS-1:0] sgn;
logic [NUBITS-1:0] neg;
logic [NUBITS-1:0] negm;
logic [NUBITS-1:0] abs;
logic [NUBITS-1:0] absm;
logic [NUBITS-1:0] pst;
logic [NUBITS-1:0] pstm;

ula_word_u fsgn;                               // Float view results
ula_word_u fneg;
ula_word_u fnegm;
ula_word_u fabs;
ula_word_u fabsm;
ula_word_u fpst;
ula_word_u fpstm;

logic [NUBITS-1:0] ann;
logic [NUBITS-1:0] orr;
logic [NUBITS-1:0] cor;
logic [NUBITS-1:0] inv;
logic [NUBITS-1:0] invm;
logic [NUBITS-1:0] shl;
logic [NUBITS-1:0] shr;
logic [NUBITS-1:0] srs;

logic [NUBITS-1:0] lan;
logic [NUBITS-1:0] lor;
logic [NUBITS-1:0] lin;
logic [NUBITS-1:0] linm;
logic [NUBITS-1:0] les;
logic [NUBITS-1:0] gre;
logic [NUBITS-1:0] equ;

// Operation units *********************************************************

// Integer units see the integer view
ula_arith ula_arith_inst (
	.in1  (in1.i),
	.in2  (in2.i),
	.add  (add),
	.mlt  (mlt),
	.sgn  (sgn),
	.neg  (neg),
	.negm (negm),
	.abs  (abs),
	.absm (absm),
	.pst  (pst),
	.pstm (pstm)
);

ula_fsign ula_fsign_inst (
	.in1   (in1),
	.in2   (in2),
	.fsgn  (fsgn),
	.fneg  (fneg),
	.fnegm (fnegm),
	.fabs  (fabs),
	.fabsm (fabsm),
	.fpst  (fpst),
	.fpstm (fpstm)
);

ula_logic ula_logic_inst (
	.in1  (in1.i),
	.in2  (in2.i),
	.ann  (ann),
	.orr  (orr),
	.cor  (cor),
	.inv  (inv),
	.invm (invm),
	.shl  (shl),
	.shr  (shr),
	.srs  (srs)
);

ula_cond ula_cond_inst (
	.in1  (in1.i),
	.in2  (in2.i),
	.lan  (lan),
	.lor  (lor),
	.lin  (lin),
	.linm (linm),
	.les  (les),
	.gre  (gre),
	.equ  (equ)
);

// Select and register
ula_mux ula_mux_inst (
	.clk   (clk),
	.reset (reset),
	.op    (op),
	.in1   (in1),
	.in2   (in2),
	.add   (add),
	.mlt   (mlt),
	.sgn   (sgn),
	.neg   (neg),
	.negm  (negm),
	.abs   (abs),
	.absm  (absm),
	.pst   (pst),
	.pstm  (pstm),
	.fsgn  (fsgn),
	.fneg  (fneg),
	.fnegm (fnegm),
	.fabs  (fabs),
	.fabsm (fabsm),
	.fpst  (fpst),
	.fpstm (fpstm),
	.ann   (ann),
	.orr   (orr),
	.cor   (cor),
	.inv   (inv),
	.invm  (invm),
	.shl   (shl),
	.shr   (shr),
	.srs   (srs),
	.lan   (lan),
	.lor   (lor),
	.lin   (lin),
	.linm  (linm),
	.les   (les),
	.gre   (gre),
	.equ   (equ),
	.out   (out)
);

endmodule

`default_nettype wire

//--- ula_arith.sv
// *************************************************************************
// Integer arithmetic on two's-complement words, purely combinational
// Results wrap to the word width and the most negative value negates to itself
// *************************************************************************

`timescale 1ns/1ps
`default_nettype none

module ula_arith (
	input  logic [ula_pkg::NUBITS-1:0] in1,    // Memory operand
	input  logic [ula_pkg::NUBITS-1:0] in2,    // Accumulator operand
	output logic [ula_pkg::NUBITS-1:0] add,
	output logic [ula_pkg::NUBITS-1:0] mlt,
	output logic [ula_pkg::NUBITS-1:0] sgn,
	output logic [ula_pkg::NUBITS-1:0] neg,
	output logic [ula_pkg::NUBITS-1:0] negm,
	output logic [ula_pkg::NUBITS-1:0] abs,
	output logic [ula_pkg::NUBITS-1:0] absm,
	output logic [ula_pkg::NUBITS-1:0] pst,
	output logic [ula_pkg::NUBITS-1:0] pstm
);

import ula_pkg::*;

// Magnitude of a signed word
function automatic logic [NUBITS-1:0] mag(input logic [NUBITS-1:0] x);
	return x[NUBITS-1] ? -x : x;
endfunction

// Negative words clamp to zero
function automatic logic [NUBITS-1:0] clamp_pos(input logic [NUBITS-1:0] x);
	return x[NUBITS-1] ? '0 : x;
endfunction

logic same_sign;                               // Operands agree in sign

assign same_sign = (in1[NUBITS-1] == in2[NUBITS-1]);

assign add  = in1 + in2;                       // Carry out dropped
assign mlt  = in1 * in2;                       // Low bits match signed product
assign sgn  = same_sign ? in2 : -in2;          // in2 takes the sign of in1

// Unary forms, plain on in2 and _M on in1
assign neg  = -in2;
assign negm = -in1;
assign abs  = mag(in2);
assign absm = mag(in1);
assign pst  = clamp_pos(in2);
assign pstm = clamp_pos(in1);

endmodule

`default_nettype wire

//--- ula_cond.sv
// *************************************************************************
// Logical and compare operations, each result is the word 1 or the word 0
// Nonzero reads as true and compares are signed
// *************************************************************************

`timescale 1ns/1ps
`default_nettype none

module ula_cond (
	input  logic [ula_pkg::NUBITS-1:0] in1,    // Memory operand
	input  logic [ula_pkg::NUBITS-1:0] in2,    // Accumulator operand
	output logic [ula_pkg::NUBITS-1:0] lan,
	output logic [ula_pkg::NUBITS-1:0] lor,
	output logic [ula_pkg::NUBITS-1:0] lin,
	output logic [ula_pkg::NUBITS-1:0] linm,
	output logic [ula_pkg::NUBITS-1:0] les,
	output logic [ula_pkg::NUBITS-1:0] gre,
	output logic [ula_pkg::NUBITS-1:0] equ
);

import ula_pkg::*;

// Widen a flag to a full word
function automatic logic [NUBITS-1:0] flag(input logic c);
	return {{(NUBITS-1){1'b0}}, c};
endfunction

logic nz1;                                     // in1 is true
logic nz2;                                     // in2 is true

assign nz1 = |in1;
assign nz2 = |in2;

assign lan  = flag(nz1 && nz2);
assign lor  = flag(nz1 || nz2);
assign lin  = flag(!nz2);
assign linm = flag(!nz1);

// in1 against in2
assign les = flag($signed(in1) < $signed(in2));
assign gre = flag($signed(in1) > $signed(in2));
assign equ = flag(in1 == in2);

endmodule

`default_nettype wire

//--- ula_fsign.sv
// *************************************************************************
// Float sign-field operations, purely combinational
// Exponent and mantissa pass unchanged, no rounding or normalizing here
// *************************************************************************

`timescale 1ns/1ps
`default_nettype none

module ula_fsign (
	input  ula_pkg::ula_word_u in1,            // Memory operand
	input  ula_pkg::ula_word_u in2,            // Accumulator operand
	output ula_pkg::ula_word_u fsgn,
	output ula_pkg::ula_word_u fneg,
	output ula_pkg::ula_word_u fnegm,
	output ula_pkg::ula_word_u fabs,
	output ula_pkg::ula_word_u fabsm,
	output ula_pkg::ula_word_u fpst,
	output ula_pkg::ula_word_u fpstm
);

import ula_pkg::*;

function automatic ula_word_u flip_sign(input ula_word_u x);
	ula_word_u r;
	r     = x;
	r.f.s = ~x.f.s;                            // Only the sign bit moves
	return r;
endfunction

function automatic ula_word_u clear_sign(input ula_word_u x);
	ula_word_u r;
	r     = x;
	r.f.s = 1'b0;
	return r;
endfunction

// Negative floats become the float zero word
function automatic ula_word_u zero_if_neg(input ula_word_u x);
	return x.f.s ? FLT_ZERO : x;
endfunction

// Sign from in1, exponent and mantissa from in2
always_comb begin
	fsgn.f.s = in1.f.s;
	fsgn.f.e = in2.f.e;
	fsgn.f.m = in2.f.m;
end

assign fneg  = flip_sign(in2);
assign fnegm = flip_sign(in1);
assign fabs  = clear_sign(in2);
assign fabsm = clear_sign(in1);
assign fpst  = zero_if_neg(in2);
assign fpstm = zero_if_neg(in1);

endmodule

`default_nettype wire

//--- ula_logic.sv
// *************************************************************************
// Bitwise operations and shifts of in1 by in2, purely combinational
// The shift amount is all of in2 read unsigned, 32 or more empties the word
// *************************************************************************

`timescale 1ns/1ps
`default_nettype none

module ula_logic (
	input  logic [ula_pkg::NUBITS-1:0] in1,    // Memory operand, shifted word
	input  logic [ula_pkg::NUBITS-1:0] in2,    // Accumulator operand, amount
	output logic [ula_pkg::NUBITS-1:0] ann,
	output logic [ula_pkg::NUBITS-1:0] orr,
	output logic [ula_pkg::NUBITS-1:0] cor,
	output logic [ula_pkg::NUBITS-1:0] inv,
	output logic [ula_pkg::NUBITS-1:0] invm,
	output logic [ula_pkg::NUBITS-1:0] shl,
	output logic [ula_pkg::NUBITS-1:0] shr,
	output logic [ula_pkg::NUBITS-1:0] srs
);

import ula_pkg::*;

localparam int SH_W = $clog2(NUBITS);          // Bits that index a position

logic        [SH_W-1:0]   amt;                 // In-range part of amount
logic                     over;                // Amount past the word
logic signed [NUBITS-1:0] srs_raw;             // Arithmetic shift kept signed

assign amt  = in2[SH_W-1:0];
assign over = |in2[NUBITS-1:SH_W];

assign ann  = in1 & in2;
assign orr  = in1 | in2;
assign cor  = in1 ^ in2;
assign inv  = ~in2;
assign invm = ~in1;

assign srs_raw = $signed(in1) >>> amt;         // Own net so >>> stays arithmetic

assign shl = over ? '0 : (in1 << amt);
assign shr = over ? '0 : (in1 >> amt);
assign srs = over ? {NUBITS{in1[NUBITS-1]}} : srs_raw;   // Full sign fill

endmodule

`default_nettype wire

//--- ula_mux.sv
// *************************************************************************
// Op decode, result select and the single output register
// Codes that are not built give zero, out clears on synchronous reset
// *************************************************************************

`timescale 1ns/1ps
`default_nettype none

module ula_mux (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [ula_pkg::OP_W-1:0]   op,
	input  ula_pkg::ula_word_u         in1,
	input  ula_pkg::ula_word_u         in2,
	// Integer units
	input  logic [ula_pkg::NUBITS-1:0] add,
	input  logic [ula_pkg::NUBITS-1:0] mlt,
	input  logic [ula_pkg::NUBITS-1:0] sgn,
	input  logic [ula_pkg::NUBITS-1:0] neg,
	input  logic [ula_pkg::NUBITS-1:0] negm,
	input  logic [ula_pkg::NUBITS-1:0] abs,
	input  logic [ula_pkg::NUBITS-1:0] absm,
	input  logic [ula_pkg::NUBITS-1:0] pst,
	input  logic [ula_pkg::NUBITS-1:0] pstm,
	// Float sign unit
	input  ula_pkg::ula_word_u         fsgn,
	input  ula_pkg::ula_word_u         fneg,
	input  ula_pkg::ula_word_u         fnegm,
	input  ula_pkg::ula_word_u         fabs,
	input  ula_pkg::ula_word_u         fabsm,
	input  ula_pkg::ula_word_u         fpst,
	input  ula_pkg::ula_word_u         fpstm,
	// Bitwise and shift unit
	input  logic [ula_pkg::NUBITS-1:0] ann,
	input  logic [ula_pkg::NUBITS-1:0] orr,
	input  logic [ula_pkg::NUBITS-1:0] cor,
	input  logic [ula_pkg::NUBITS-1:0] inv,
	input  logic [ula_pkg::NUBITS-1:0] invm,
	input  logic [ula_pkg::NUBITS-1:0] shl,
	input  logic [ula_pkg::NUBITS-1:0] shr,
	input  logic [ula_pkg::NUBITS-1:0] srs,
	// Conditional unit
	input  logic [ula_pkg::NUBITS-1:0] lan,
	input  logic [ula_pkg::NUBITS-1:0] lor,
	input  logic [ula_pkg::NUBITS-1:0] lin,
	input  logic [ula_pkg::NUBITS-1:0] linm,
	input  logic [ula_pkg::NUBITS-1:0] les,
	input  logic [ula_pkg::NUBITS-1:0] gre,
	input  logic [ula_pkg::NUBITS-1:0] equ,
	output ula_pkg::ula_word_u         out       // One cycle after op
);

import ula_pkg::*;

ula_word_u sel;                                // Result picked this cycle

// Result select ***********************************************************

always_comb begin
	case (op)
		OP_NOP:     sel = in2;
		OP_LOD:     sel = in1;
		OP_ADD:     sel.i = add;
		OP_MLT:     sel.i = mlt;
		OP_SGN:     sel.i = sgn;
		OP_F_SGN:   sel = fsgn;
		OP_NEG:     sel.i = neg;
		OP_NEG_M:   sel.i = negm;
		OP_F_NEG:   sel = fneg;
		OP_F_NEG_M: sel = fnegm;
		OP_ABS:     sel.i = abs;
		OP_ABS_M:   sel.i = absm;
		OP_F_ABS:   sel = fabs;
		OP_F_ABS_M: sel = fabsm;
		OP_PST:     sel.i = pst;
		OP_PST_M:   sel.i = pstm;
		OP_F_PST:   sel = fpst;
		OP_F_PST_M: sel = fpstm;
		OP_AND:     sel.i = ann;
		OP_ORR:     sel.i = orr;
		OP_XOR:     sel.i = cor;
		OP_INV:     sel.i = inv;
		OP_INV_M:   sel.i = invm;
		OP_LAN:     sel.i = lan;
		OP_LOR:     sel.i = lor;
		OP_LIN:     sel.i = lin;
		OP_LIN_M:   sel.i = linm;
		OP_LES:     sel.i = les;
		OP_GRE:     sel.i = gre;
		OP_EQU:     sel.i = equ;
		OP_SHL:     sel.i = shl;
		OP_SHR:     sel.i = shr;
		OP_SRS:     sel.i = srs;
		default:    sel = '0;                  // Float math, divide and spare codes
	endcase
end

// Output register *********************************************************

always_ff @(posedge clk) begin
	if (reset) begin
		out <= '0;
	end else begin
		out <= sel;                            // Holds while inputs hold
	end
end

endmodule

`default_nettype wire

//--- ula_pkg.sv
// *************************************************************************
// Word layout and op codes shared by every ALU block
// Float word is sign, 8-bit two's-complement exponent, 23-bit mantissa
// The mantissa has no hidden bit
// *************************************************************************

`default_nettype none

package ula_pkg;

	localparam int NUBITS = 32;           // Data word
	localparam int NBMANT = 23;           // Mantissa field
	localparam int NBEXPO = 8;            // Exponent field
	localparam int OP_W   = 6;            // Op code

	// Op codes ************************************************************
	// Gaps in the numbering are codes that are not built

	localparam logic [OP_W-1:0] OP_NOP     = 6'd0;    // Pass in2
	localparam logic [OP_W-1:0] OP_LOD     = 6'd1;    // Pass in1
	localparam logic [OP_W-1:0] OP_ADD     = 6'd2;
	localparam logic [OP_W-1:0] OP_MLT     = 6'd4;    // Low half of product
	localparam logic [OP_W-1:0] OP_SGN     = 6'd9;
	localparam logic [OP_W-1:0] OP_F_SGN   = 6'd10;
	localparam logic [OP_W-1:0] OP_NEG     = 6'd11;
	localparam logic [OP_W-1:0] OP_NEG_M   = 6'd12;
	localparam logic [OP_W-1:0] OP_F_NEG   = 6'd13;
	localparam logic [OP_W-1:0] OP_F_NEG_M = 6'd14;
	localparam logic [OP_W-1:0] OP_ABS     = 6'd15;
	localparam logic [OP_W-1:0] OP_ABS_M   = 6'd16;
	localparam logic [OP_W-1:0] OP_F_ABS   = 6'd17;
	localparam logic [OP_W-1:0] OP_F_ABS_M = 6'd18;
	localparam logic [OP_W-1:0] OP_PST     = 6'd19;
	localparam logic [OP_W-1:0] OP_PST_M   = 6'd20;
	localparam logic [OP_W-1:0] OP_F_PST   = 6'd21;
	localparam logic [OP_W-1:0] OP_F_PST_M = 6'd22;
	localparam logic [OP_W-1:0] OP_AND     = 6'd29;
	localparam logic [OP_W-1:0] OP_ORR     = 6'd30;
	localparam logic [OP_W-1:0] OP_XOR     = 6'd31;
	localparam logic [OP_W-1:0] OP_INV     = 6'd32;
	localparam logic [OP_W-1:0] OP_INV_M   = 6'd33;
	localparam logic [OP_W-1:0] OP_LAN     = 6'd34;
	localparam logic [OP_W-1:0] OP_LOR     = 6'd35;
	localparam logic [OP_W-1:0] OP_LIN     = 6'd36;
	localparam logic [OP_W-1:0] OP_LIN_M   = 6'd37;
	localparam logic [OP_W-1:0] OP_LES     = 6'd38;
	localparam logic [OP_W-1:0] OP_GRE     = 6'd40;
	localparam logic [OP_W-1:0] OP_EQU     = 6'd42;
	localparam logic [OP_W-1:0] OP_SHL     = 6'd43;
	localparam logic [OP_W-1:0] OP_SHR     = 6'd44;
	localparam logic [OP_W-1:0] OP_SRS     = 6'd45;

	// One data word read as integer or as float
	typedef union packed {
		logic signed [NUBITS-1:0] i;              // Integer view
		struct packed {
			logic                     s;          // Sign, 1 is negative
			logic signed [NBEXPO-1:0] e;          // Exponent
			logic        [NBMANT-1:0] m;          // Mantissa
		} f;                                      // Float view
	} ula_word_u;

	// Float zero has the most negative exponent
	localparam ula_word_u FLT_ZERO = {1'b0, 1'b1, {(NBEXPO-1){1'b0}}, {NBMANT{1'b0}}};

endpackage

`default_nettype wire
